// ==== Bender.yml ====
package:
  name: sample_buffer

sources:
  - files:
      - logic/sample_buffer_pkg.sv
      - logic/playback_ctrl_if.sv
      - logic/sample_buffer_csr.sv
      - logic/sample_ram.sv
      - logic/playback_sequencer.sv
      - logic/stream_fifo.sv
      - logic/sample_buffer_top.sv
  - target: test
    files:
      - test/sample_buffer_tb.sv

// ==== logic/playback_ctrl_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface playback_ctrl_if;

  logic active;
  logic one_shot;
  logic [sample_buffer_pkg::addr_width-1:0] start_offset;
  logic [sample_buffer_pkg::addr_width-1:0] end_offset;
  // single cycle, applies active and reloads the address
  logic update;
  logic stopped;

  modport csr (
    output active,
    output one_shot,
    output start_offset,
    output end_offset,
    output update,
    input  stopped
  );

  modport sequencer (
    input  active,
    input  one_shot,
    input  start_offset,
    input  end_offset,
    input  update,
    output stopped
  );

endinterface

`default_nettype wire

// ==== logic/playback_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module playback_sequencer (
  input  logic                                        stream_out,
  input  logic                                        arst_n,
  playback_ctrl_if.sequencer                          ctrl,
  input  logic                                        almost_full,
  output logic [sample_buffer_pkg::addr_width-1:0]    rd_addr,
  input  logic [sample_buffer_pkg::sample_width-1:0]  rd_data,
  output logic                                        push,
  output logic [sample_buffer_pkg::sample_width-1:0]  push_data
);

  logic enable;
  logic issue;
  logic at_end;
  logic [sample_buffer_pkg::addr_width-1:0] addr;
  // one bit per cycle of RAM read latency
  logic [sample_buffer_pkg::read_latency-1:0] valid_sr;

  // no read on an update cycle, the address is about to be reloaded
  assign issue = enable && !almost_full && !ctrl.update;
  assign at_end = (addr >= ctrl.end_offset);
  assign rd_addr = addr;

  always_ff @(posedge stream_out or negedge arst_n) begin
    if (!arst_n) begin
      enable <= 1'b0;
      addr <= '0;
    end else if (ctrl.update) begin
      enable <= ctrl.active;
      if (ctrl.active) begin
        addr <= ctrl.start_offset;
      end
    end else if (issue) begin
      if (at_end) begin
        addr <= ctrl.start_offset;
        // one-shot playback ends with the read of the last sample
        if (ctrl.one_shot) begin
          enable <= 1'b0;
        end
      end else begin
        addr <= addr + 1'b1;
      end
    end
  end

  always_ff @(posedge stream_out or negedge arst_n) begin
    if (!arst_n) begin
      valid_sr <= '0;
    end else begin
      valid_sr[0] <= issue;
      for (int i = 1; i < sample_buffer_pkg::read_latency; i++) begin
        valid_sr[i] <= valid_sr[i-1];
      end
    end
  end

  assign push = valid_sr[sample_buffer_pkg::read_latency-1];
  assign push_data = rd_data;

  assign ctrl.stopped = ~enable;

endmodule

`default_nettype wire

// ==== logic/sample_buffer_csr.sv ====
`timescale 1ns/1ns
`default_nettype none

module sample_buffer_csr (
  input  logic                                          stream_out,
  input  logic                                          arst_n,
  input  logic                                          reg_write,
  input  logic [sample_buffer_pkg::reg_addr_width-1:0]  reg_addr,
  input  sample_buffer_pkg::csr_word_u                  reg_wdata,
  input  logic                                          trigger,
  playback_ctrl_if.csr                                  ctrl
);

  logic ctrl_write;
  logic upd_req;
  logic upd_pending;

  assign ctrl_write = reg_write && (reg_addr == sample_buffer_pkg::reg_control);
  assign upd_req = ctrl_write || trigger;

  always_ff @(posedge stream_out or negedge arst_n) begin
    if (!arst_n) begin
      ctrl.active <= 1'b0;
      ctrl.one_shot <= 1'b0;
      ctrl.start_offset <= '0;
      ctrl.end_offset <= '0;
    end else begin
      if (ctrl_write) begin
        ctrl.one_shot <= reg_wdata.control.one_shot;
      end
      // trigger restarts playback even when the host left it inactive
      if (trigger) begin
        ctrl.active <= 1'b1;
      end else if (ctrl_write) begin
        ctrl.active <= reg_wdata.control.active;
      end
      if (reg_write && (reg_addr == sample_buffer_pkg::reg_start)) begin
        ctrl.start_offset <= reg_wdata.offset.addr;
      end
      if (reg_write && (reg_addr == sample_buffer_pkg::reg_end)) begin
        ctrl.end_offset <= reg_wdata.offset.addr;
      end
    end
  end

  // a request arriving while update is high is held for one cycle so
  // that back to back writes still reach the sequencer with the latest settings
  always_ff @(posedge stream_out or negedge arst_n) begin
    if (!arst_n) begin
      ctrl.update <= 1'b0;
      upd_pending <= 1'b0;
    end else if (ctrl.update) begin
      ctrl.update <= 1'b0;
      upd_pending <= upd_req;
    end else begin
      ctrl.update <= upd_req || upd_pending;
      upd_pending <= 1'b0;
    end
  end

  update_single_cycle: assert property (
    @(posedge stream_out) disable iff (!arst_n)
    ctrl.update |=> !ctrl.update
  );

endmodule

`default_nettype wire

// ==== logic/sample_buffer_pkg.sv ====
`default_nettype none

package sample_buffer_pkg;

  // sample and stream word width
  localparam int sample_width = 16;

  // 256 samples of storage
  localparam int addr_width = 8;
  localparam int ram_depth = 1 << addr_width;

  localparam int reg_addr_width = 2;
  localparam int reg_width = 16;

  localparam logic [reg_addr_width-1:0] reg_control = 2'd0;
  localparam logic [reg_addr_width-1:0] reg_start = 2'd1;
  localparam logic [reg_addr_width-1:0] reg_end = 2'd2;

  localparam int read_latency = 1;

  localparam int fifo_depth = 16;
  localparam int fifo_ptr_width = $clog2(fifo_depth);
  // leaves room for the reads still in flight when the sequencer stops
  localparam int fifo_almost_full = 14;

  // a register write is read as control bits or as an offset,
  // depending on the register address
  typedef union packed {
    struct packed {
      logic [reg_width-3:0] reserved;
      logic one_shot;
      logic active;
    } control;
    struct packed {
      logic [reg_width-addr_width-1:0] reserved;
      logic [addr_width-1:0] addr;
    } offset;
  } csr_word_u;

endpackage

`default_nettype wire

// ==== logic/sample_buffer_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module sample_buffer_top (
  input  logic                                          stream_out,
  input  logic                                          arst_n,
  input  logic                                          reg_write,
  input  logic [sample_buffer_pkg::reg_addr_width-1:0]  reg_addr,
  input  logic [sample_buffer_pkg::reg_width-1:0]       reg_wdata,
  input  logic                                          mem_write,
  input  logic [sample_buffer_pkg::addr_width-1:0]      mem_addr,
  input  logic [sample_buffer_pkg::sample_width-1:0]    mem_wdata,
  input  logic                                          trigger,
  output logic                                          tvalid,
  input  logic                                          tready,
  output logic [sample_buffer_pkg::sample_width-1:0]    tdata,
  output logic                                          stopped
);

  logic [sample_buffer_pkg::addr_width-1:0] rd_addr;
  logic [sample_buffer_pkg::sample_width-1:0] rd_data;
  logic push;
  logic [sample_buffer_pkg::sample_width-1:0] push_data;
  logic almost_full;

  playback_ctrl_if ctrl ();

  // the plain register word is taken as the union view by the port
  sample_buffer_csr i_csr (
    .stream_out (stream_out),
    .arst_n     (arst_n),
    .reg_write  (reg_write),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .trigger    (trigger),
    .ctrl       (ctrl.csr)
  );

  sample_ram i_ram (
    .stream_out (stream_out),
    .wr_en      (mem_write),
    .wr_addr    (mem_addr),
    .wr_data    (mem_wdata),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

  playback_sequencer i_sequencer (
    .stream_out  (stream_out),
    .arst_n      (arst_n),
    .ctrl        (ctrl.sequencer),
    .almost_full (almost_full),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .push        (push),
    .push_data   (push_data)
  );

  stream_fifo i_fifo (
    .stream_out  (stream_out),
    .arst_n      (arst_n),
    .push        (push),
    .push_data   (push_data),
    .almost_full (almost_full),
    .tvalid      (tvalid),
    .tready      (tready),
    .tdata       (tdata)
  );

  assign stopped = ctrl.stopped;

endmodule

`default_nettype wire

// ==== logic/sample_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module sample_ram (
  input  logic                                        stream_out,
  input  logic                                        wr_en,
  input  logic [sample_buffer_pkg::addr_width-1:0]    wr_addr,
  input  logic [sample_buffer_pkg::sample_width-1:0]  wr_data,
  input  logic [sample_buffer_pkg::addr_width-1:0]    rd_addr,
  output logic [sample_buffer_pkg::sample_width-1:0]  rd_data
);

  logic [sample_buffer_pkg::sample_width-1:0] mem [0:sample_buffer_pkg::ram_depth-1];

  // host write port
  always_ff @(posedge stream_out) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, data follows the address by one cycle
  always_ff @(posedge stream_out) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== logic/stream_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module stream_fifo (
  input  logic                                        stream_out,
  input  logic                                        arst_n,
  input  logic                                        push,
  input  logic [sample_buffer_pkg::sample_width-1:0]  push_data,
  output logic                                        almost_full,
  output logic                                        tvalid,
  input  logic                                        tready,
  output logic [sample_buffer_pkg::sample_width-1:0]  tdata
);

  logic [sample_buffer_pkg::sample_width-1:0] mem [0:sample_buffer_pkg::fifo_depth-1];
  logic [sample_buffer_pkg::fifo_ptr_width-1:0] wr_ptr;
  logic [sample_buffer_pkg::fifo_ptr_width-1:0] rd_ptr;
  logic [sample_buffer_pkg::fifo_ptr_width:0] count;
  logic pop;

  assign pop = tvalid && tready;

  // first word fall-through, the head entry is always on tdata
  assign tvalid = (count != '0);
  assign tdata = mem[rd_ptr];
  assign almost_full = (count >= sample_buffer_pkg::fifo_almost_full);

  always_ff @(posedge stream_out) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // depth is a power of two so the pointers wrap on their own
  always_ff @(posedge stream_out or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the almost-full margin must cover every read the sequencer has in flight
  no_push_when_full: assert property (
    @(posedge stream_out) disable iff (!arst_n)
    push |-> (count < sample_buffer_pkg::fifo_depth)
  );

  tdata_stable_when_stalled: assert property (
    @(posedge stream_out) disable iff (!arst_n)
    (tvalid && !tready) |=> (tvalid && $stable(tdata))
  );

endmodule

`default_nettype wire

// ==== src.f ====
logic/sample_buffer_pkg.sv
logic/playback_ctrl_if.sv
logic/sample_buffer_csr.sv
logic/sample_ram.sv
logic/playback_sequencer.sv
logic/stream_fifo.sv
logic/sample_buffer_top.sv
test/sample_buffer_tb.sv

// ==== test/sample_buffer_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module sample_buffer_tb;

  localparam int loop_start = 16;
  localparam int loop_end = 40;
  localparam int shot_start = 100;
  localparam int shot_end = 119;
  localparam int long_start = 200;
  localparam int long_end = 239;
  localparam int rand_start = 50;
  localparam int rand_end = 90;
  localparam int rand_cycles = 400;
  localparam int stale_limit = sample_buffer_pkg::fifo_depth + sample_buffer_pkg::read_latency;

  // rough length of each test in clock cycles
  localparam int load_len = sample_buffer_pkg::ram_depth + 10;
  localparam int loop_len = 3 * (loop_end - loop_start + 1) + 40;
  localparam int shot_len = 2 * (shot_end - shot_start + 1) + 60;
  localparam int long_len = (long_end - long_start + 1) + stale_limit + 40;
  localparam int rand_len = 2 * rand_cycles + 2 * stale_limit + 40;
  localparam int cycle_limit = 4 * (20 + load_len + loop_len + shot_len + long_len + rand_len);

  localparam logic [15:0] ctrl_off = 16'h0000;
  localparam logic [15:0] ctrl_loop = 16'h0001;
  localparam logic [15:0] ctrl_one_shot = 16'h0003;

  logic stream_out;
  logic arst_n;
  logic reg_write;
  logic [sample_buffer_pkg::reg_addr_width-1:0] reg_addr;
  logic [sample_buffer_pkg::reg_width-1:0] reg_wdata;
  logic mem_write;
  logic [sample_buffer_pkg::addr_width-1:0] mem_addr;
  logic [sample_buffer_pkg::sample_width-1:0] mem_wdata;
  logic trigger;
  logic tvalid;
  logic tready;
  logic [sample_buffer_pkg::sample_width-1:0] tdata;
  logic stopped;

  int error_count = 0;
  int xfer_count = 0;
  int cycle_count = 0;
  string test_name = "reset";
  logic [15:0] lfsr_state = 16'd40515;

  // reference model of the RAM and of the playback order
  logic [sample_buffer_pkg::sample_width-1:0] ram_model [0:sample_buffer_pkg::ram_depth-1];
  logic [sample_buffer_pkg::addr_width-1:0] m_start = '0;
  logic [sample_buffer_pkg::addr_width-1:0] m_end = '0;
  logic m_one_shot = 1'b0;
  logic [sample_buffer_pkg::addr_width-1:0] cur_start = '0;
  logic [sample_buffer_pkg::addr_width-1:0] cur_end = '0;
  logic cur_one_shot = 1'b0;
  logic [sample_buffer_pkg::addr_width-1:0] new_start = '0;
  logic [sample_buffer_pkg::addr_width-1:0] new_end = '0;
  logic new_one_shot = 1'b0;
  logic [sample_buffer_pkg::addr_width-1:0] exp_ptr = '0;
  int seq_left = 0;
  int budget = -1;
  logic seq_active = 1'b0;
  logic restart_pending = 1'b0;
  logic os_done = 1'b0;
  logic seen_control = 1'b0;

  logic take_new;
  logic xfer_allowed;
  logic stop_write;
  logic [sample_buffer_pkg::sample_width-1:0] exp_data;

  sample_buffer_top i_sample_buffer_top (
    .stream_out (stream_out),
    .arst_n     (arst_n),
    .reg_write  (reg_write),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .trigger    (trigger),
    .tvalid     (tvalid),
    .tready     (tready),
    .tdata      (tdata),
    .stopped    (stopped)
  );

  initial begin
    stream_out = 1'b0;
    forever #10 stream_out = ~stream_out;
  end

  function automatic logic [15:0] lfsr_advance(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  task automatic random_bits(input int n, output logic [15:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_advance(lfsr_state);
      value = {value[14:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [7:0] next_addr(input logic [7:0] ptr, input logic [7:0] first,
                                           input logic [7:0] last);
    return (ptr == last) ? first : ptr + 8'd1;
  endfunction

  // a restart may still be preceded by words read ahead under the old settings
  assign take_new = restart_pending && (tdata == ram_model[new_start]);
  assign exp_data = take_new ? ram_model[new_start] : ram_model[exp_ptr];
  assign xfer_allowed = take_new || (seq_active && budget != 0);
  assign stop_write = reg_write && (reg_addr == sample_buffer_pkg::reg_control) && !reg_wdata[0];

  always @(posedge stream_out) begin
    int left;
    if (arst_n && tvalid && tready) begin
      xfer_count <= xfer_count + 1;
      if (take_new) begin
        left = new_end - new_start;
        restart_pending <= 1'b0;
        budget <= -1;
        cur_start <= new_start;
        cur_end <= new_end;
        cur_one_shot <= new_one_shot;
        exp_ptr <= next_addr(new_start, new_start, new_end);
        seq_left <= left;
        seq_active <= !(new_one_shot && left == 0);
        os_done <= new_one_shot && left == 0;
      end else begin
        exp_ptr <= next_addr(exp_ptr, cur_start, cur_end);
        if (budget > 0) begin
          budget <= budget - 1;
        end
        if (cur_one_shot) begin
          seq_left <= seq_left - 1;
          if (seq_left == 1) begin
            seq_active <= 1'b0;
            os_done <= 1'b1;
          end
        end
      end
    end
    if (arst_n && reg_write) begin
      if (reg_addr == sample_buffer_pkg::reg_start) begin
        m_start <= reg_wdata[7:0];
      end else if (reg_addr == sample_buffer_pkg::reg_end) begin
        m_end <= reg_wdata[7:0];
      end else if (reg_addr == sample_buffer_pkg::reg_control) begin
        seen_control <= 1'b1;
        m_one_shot <= reg_wdata[1];
        if (reg_wdata[0]) begin
          restart_pending <= 1'b1;
          budget <= stale_limit;
          new_start <= m_start;
          new_end <= m_end;
          new_one_shot <= reg_wdata[1];
        end else begin
          budget <= stale_limit;
        end
      end
    end
    if (arst_n && trigger) begin
      restart_pending <= 1'b1;
      budget <= stale_limit;
      new_start <= m_start;
      new_end <= m_end;
      new_one_shot <= m_one_shot;
    end
  end

  always @(posedge stream_out) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout in %s after %0d cycles, %0d errors so far", test_name, cycle_count,
               error_count);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  reset_idle: assert property (
    @(posedge stream_out) disable iff (!arst_n)
    !seen_control |-> (!tvalid && stopped)
  ) else begin
    error_count++;
    $display("%s: output left the idle state before the first control write", test_name);
  end

  sample_order: assert property (
    @(posedge stream_out) disable iff (!arst_n)
    (tvalid && tready && xfer_allowed) |-> (tdata == exp_data)
  ) else begin
    error_count++;
    $display("ERROR %s: expected %h, actual %h", test_name, $sampled(exp_data), $sampled(tdata));
  end

  no_extra_transfer: assert property (
    @(posedge stream_out) disable iff (!arst_n)
    (tvalid && tready) |-> xfer_allowed
  ) else begin
    error_count++;
    $display("%s: a sample transferred when none was expected", test_name);
  end

  stall_holds_word: assert property (
    @(posedge stream_out) disable iff (!arst_n)
    (tvalid && !tready) |=> (tvalid && $stable(tdata))
  ) else begin
    error_count++;
    $display("%s: tvalid or tdata changed while the stream was stalled", test_name);
  end

  stop_raises_stopped: assert property (
    @(posedge stream_out) disable iff (!arst_n)
    stop_write |=> ##2 stopped
  ) else begin
    error_count++;
    $display("%s: stopped did not rise after playback was switched off", test_name);
  end

  shot_drained_idle: assert property (
    @(posedge stream_out) disable iff (!arst_n)
    (os_done && !restart_pending) |-> (stopped && !tvalid)
  ) else begin
    error_count++;
    $display("%s: output still active after the one-shot range was played", test_name);
  end

  task automatic reg_wr(input logic [1:0] addr, input logic [15:0] data);
    @(negedge stream_out);
    reg_write = 1'b1;
    reg_addr = addr;
    reg_wdata = data;
    @(negedge stream_out);
    reg_write = 1'b0;
  endtask

  task automatic pulse_trigger();
    @(negedge stream_out);
    trigger = 1'b1;
    @(negedge stream_out);
    trigger = 1'b0;
  endtask

  // low byte of every sample is its own address, so each word is unique
  task automatic load_ram();
    logic [15:0] bits;
    for (int a = 0; a < sample_buffer_pkg::ram_depth; a++) begin
      random_bits(8, bits);
      @(negedge stream_out);
      mem_write = 1'b1;
      mem_addr = a[7:0];
      mem_wdata = {bits[7:0], a[7:0]};
      ram_model[a] = {bits[7:0], a[7:0]};
    end
    @(negedge stream_out);
    mem_write = 1'b0;
  endtask

  task automatic set_range(input int first, input int last, input logic [15:0] mode);
    reg_wr(sample_buffer_pkg::reg_start, first[15:0]);
    reg_wr(sample_buffer_pkg::reg_end, last[15:0]);
    reg_wr(sample_buffer_pkg::reg_control, mode);
  endtask

  task automatic wait_xfers(input int n);
    int target;
    target = xfer_count + n;
    while (xfer_count < target) begin
      @(negedge stream_out);
    end
  endtask

  task automatic wait_idle();
    while (!(stopped && !tvalid)) begin
      @(negedge stream_out);
    end
  endtask

  task automatic wait_shot_done();
    while (!(os_done && !restart_pending)) begin
      @(negedge stream_out);
    end
    repeat (10) @(negedge stream_out);
  endtask

  initial begin
    logic [15:0] bits;
    arst_n = 1'b0;
    reg_write = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    mem_write = 1'b0;
    mem_addr = '0;
    mem_wdata = '0;
    trigger = 1'b0;
    tready = 1'b1;
    repeat (3) @(negedge stream_out);
    arst_n = 1'b1;
    repeat (5) @(negedge stream_out);

    load_ram();

    test_name = "loop";
    set_range(loop_start, loop_end, ctrl_loop);
    wait_xfers(3 * (loop_end - loop_start + 1) + 5);

    test_name = "stop";
    reg_wr(sample_buffer_pkg::reg_control, ctrl_off);
    wait_idle();

    test_name = "one_shot";
    set_range(shot_start, shot_end, ctrl_one_shot);
    wait_shot_done();

    test_name = "trigger_after";
    pulse_trigger();
    wait_shot_done();

    test_name = "trigger_during";
    set_range(long_start, long_end, ctrl_one_shot);
    wait_xfers(10);
    pulse_trigger();
    wait_shot_done();

    test_name = "random_ready";
    set_range(rand_start, rand_end, ctrl_loop);
    for (int c = 0; c < rand_cycles; c++) begin
      random_bits(2, bits);
      @(negedge stream_out);
      tready = (bits[1:0] != 2'b00);
    end
    reg_wr(sample_buffer_pkg::reg_control, ctrl_off);
    tready = 1'b1;
    wait_idle();
    repeat (5) @(negedge stream_out);

    $display("checked %0d transfers in %0d cycles, %0d errors", xfer_count, cycle_count,
             error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
